// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing
TOP      = alu_tb
FILELIST = files.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: files.f
hw/alu_pkg.sv
hw/alu_op_if.sv
hw/alu_input_stage.sv
hw/alu_arith_unit.sv
hw/alu_logic_unit.sv
hw/alu_output_stage.sv
hw/alu_top.sv
verification/alu_tb.sv

// File: hw/alu_arith_unit.sv
`timescale 1ns/1ps

module alu_arith_unit #(
        parameter int W = alu_pkg::DEFAULT_W
) (
        alu_op_if.unit              op,
        output logic [W:0]          res,
        output alu_pkg::alu_flags_t flags
);
        import alu_pkg::*;

        logic [W:0] a_x;
        logic [W:0] b_x;
        logic [W:0] cin_x;
        logic       need_a;
        logic       need_b;
        logic       a_ok;
        logic       b_ok;
        logic       bad_cmd;
        logic       bad_valid;

        // operands widened by one bit for carry and borrow
        assign a_x   = {1'b0, op.opa};
        assign b_x   = {1'b0, op.opb};
        assign cin_x = {{W{1'b0}}, op.cin};

        always_comb begin
                need_a  = 1'b0;
                need_b  = 1'b0;
                bad_cmd = 1'b0;
                case (op.cmd)
                        CMD_ADD, CMD_SUB, CMD_ADD_CIN, CMD_SUB_CIN, CMD_CMP: begin
                                need_a = 1'b1;
                                need_b = 1'b1;
                        end
                        CMD_INC_A, CMD_DEC_A: begin
                                need_a = 1'b1;
                        end
                        CMD_INC_B, CMD_DEC_B: begin
                                need_b = 1'b1;
                        end
                        default: begin
                                bad_cmd = 1'b1;
                        end
                endcase
        end

        assign a_ok      = (op.inp_valid == VALID_A) || (op.inp_valid == VALID_AB);
        assign b_ok      = (op.inp_valid == VALID_B) || (op.inp_valid == VALID_AB);
        assign bad_valid = (need_a && !a_ok) || (need_b && !b_ok);

        always_comb begin
                res   = '0;
                flags = '0;
                if (bad_cmd || bad_valid) begin
                        flags.err = 1'b1;
                end else begin
                        case (op.cmd)
                                CMD_ADD: begin
                                        res        = a_x + b_x;
                                        flags.cout = res[W];
                                end
                                CMD_ADD_CIN: begin
                                        res        = a_x + b_x + cin_x;
                                        flags.cout = res[W];
                                end
                                CMD_SUB: begin
                                        res         = a_x - b_x;
                                        flags.oflow = a_x < b_x;
                                end
                                CMD_SUB_CIN: begin
                                        res         = a_x - b_x - cin_x;
                                        flags.oflow = a_x < (b_x + cin_x);
                                end
                                CMD_INC_A: begin
                                        res        = a_x + (W+1)'(1);
                                        flags.cout = res[W];
                                end
                                CMD_INC_B: begin
                                        res        = b_x + (W+1)'(1);
                                        flags.cout = res[W];
                                end
                                // borrow out of zero
                                CMD_DEC_A: begin
                                        res         = a_x - (W+1)'(1);
                                        flags.oflow = (op.opa == '0);
                                end
                                CMD_DEC_B: begin
                                        res         = b_x - (W+1)'(1);
                                        flags.oflow = (op.opb == '0);
                                end
                                CMD_CMP: begin
                                        flags.g = op.opa > op.opb;
                                        flags.l = op.opa < op.opb;
                                        flags.e = op.opa == op.opb;
                                end
                                default: begin
                                        res = '0;
                                end
                        endcase
                end
        end

endmodule

// File: hw/alu_input_stage.sv
`timescale 1ns/1ps

module alu_input_stage #(
        parameter int W = alu_pkg::DEFAULT_W
) (
        input  logic                      clk,
        input  logic                      rst,
        input  logic                      ce,
        input  logic [W-1:0]              opa,
        input  logic [W-1:0]              opb,
        input  logic                      cin,
        input  logic                      mode,
        input  logic [alu_pkg::CMD_W-1:0] cmd,
        input  logic [1:0]                inp_valid,
        alu_op_if.src                     op
);

        // first pipeline stage, holds while ce is low
        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        op.opa       <= '0;
                        op.opb       <= '0;
                        op.cin       <= 1'b0;
                        op.mode      <= 1'b0;
                        op.cmd       <= '0;
                        op.inp_valid <= '0;
                end else if (ce) begin
                        op.opa       <= opa;
                        op.opb       <= opb;
                        op.cin       <= cin;
                        op.mode      <= mode;
                        op.cmd       <= cmd;
                        op.inp_valid <= inp_valid;
                end
        end

endmodule

// File: hw/alu_logic_unit.sv
`timescale 1ns/1ps

module alu_logic_unit #(
        parameter int W = alu_pkg::DEFAULT_W
) (
        alu_op_if.unit              op,
        output logic [W:0]          res,
        output alu_pkg::alu_flags_t flags
);
        import alu_pkg::*;

        localparam int SH_W = $clog2(W);

        logic [SH_W-1:0] amt;
        logic            amt_bad;
        logic [2*W-1:0]  rol_x;
        logic [2*W-1:0]  ror_x;
        logic [W-1:0]    val;
        logic            need_a;
        logic            need_b;
        logic            is_rot;
        logic            bad_cmd;
        logic            bad_valid;

        // rotate through a doubled copy of A
        assign amt     = op.opb[SH_W-1:0];
        assign amt_bad = |op.opb[W-1:SH_W];
        assign rol_x   = {op.opa, op.opa} << amt;
        assign ror_x   = {op.opa, op.opa} >> amt;

        always_comb begin
                need_a  = 1'b0;
                need_b  = 1'b0;
                is_rot  = 1'b0;
                bad_cmd = 1'b0;
                val     = '0;
                case (op.cmd)
                        CMD_AND: begin
                                need_a = 1'b1;
                                need_b = 1'b1;
                                val    = op.opa & op.opb;
                        end
                        CMD_NAND: begin
                                need_a = 1'b1;
                                need_b = 1'b1;
                                val    = ~(op.opa & op.opb);
                        end
                        CMD_OR: begin
                                need_a = 1'b1;
                                need_b = 1'b1;
                                val    = op.opa | op.opb;
                        end
                        CMD_NOR: begin
                                need_a = 1'b1;
                                need_b = 1'b1;
                                val    = ~(op.opa | op.opb);
                        end
                        CMD_XOR: begin
                                need_a = 1'b1;
                                need_b = 1'b1;
                                val    = op.opa ^ op.opb;
                        end
                        CMD_XNOR: begin
                                need_a = 1'b1;
                                need_b = 1'b1;
                                val    = ~(op.opa ^ op.opb);
                        end
                        CMD_NOT_A: begin
                                need_a = 1'b1;
                                val    = ~op.opa;
                        end
                        CMD_NOT_B: begin
                                need_b = 1'b1;
                                val    = ~op.opb;
                        end
                        CMD_SHR1_A: begin
                                need_a = 1'b1;
                                val    = op.opa >> 1;
                        end
                        CMD_SHL1_A: begin
                                need_a = 1'b1;
                                val    = op.opa << 1;
                        end
                        CMD_SHR1_B: begin
                                need_b = 1'b1;
                                val    = op.opb >> 1;
                        end
                        CMD_SHL1_B: begin
                                need_b = 1'b1;
                                val    = op.opb << 1;
                        end
                        CMD_ROL_A_B: begin
                                need_a = 1'b1;
                                need_b = 1'b1;
                                is_rot = 1'b1;
                                val    = rol_x[2*W-1:W];
                        end
                        CMD_ROR_A_B: begin
                                need_a = 1'b1;
                                need_b = 1'b1;
                                is_rot = 1'b1;
                                val    = ror_x[W-1:0];
                        end
                        default: begin
                                bad_cmd = 1'b1;
                        end
                endcase
        end

        assign bad_valid = (op.inp_valid == 2'b00)
                           || (need_a && need_b && op.inp_valid != VALID_AB)
                           || (need_a && !need_b && op.inp_valid == VALID_B)
                           || (need_b && !need_a && op.inp_valid == VALID_A);

        always_comb begin
                flags = '0;
                if (bad_cmd || bad_valid || (is_rot && amt_bad)) begin
                        flags.err = 1'b1;
                        res       = '0;
                end else begin
                        res = {1'b0, val};
                end
        end

endmodule

// File: hw/alu_op_if.sv
`timescale 1ns/1ps

interface alu_op_if #(
        parameter int W = alu_pkg::DEFAULT_W
);
        logic [W-1:0]              opa;
        logic [W-1:0]              opb;
        logic                      cin;
        logic                      mode;
        logic [alu_pkg::CMD_W-1:0] cmd;
        logic [1:0]                inp_valid;

        modport src (
                output opa, opb, cin, mode, cmd, inp_valid
        );

        modport unit (
                input opa, opb, cin, mode, cmd, inp_valid
        );

endinterface

// File: hw/alu_output_stage.sv
`timescale 1ns/1ps

module alu_output_stage #(
        parameter int W = alu_pkg::DEFAULT_W
) (
        input  logic                clk,
        input  logic                rst,
        input  logic                ce,
        alu_op_if.unit              op,
        input  logic [W:0]          arith_res,
        input  logic [W:0]          logic_res,
        input  alu_pkg::alu_flags_t arith_flags,
        input  alu_pkg::alu_flags_t logic_flags,
        output logic [W:0]          res,
        output logic                cout,
        output logic                oflow,
        output logic                g,
        output logic                l,
        output logic                e,
        output logic                err
);
        import alu_pkg::*;

        logic [W:0] sel_res;
        alu_flags_t sel_flags;

        // mode 1 picks the arithmetic unit
        assign sel_res   = op.mode ? arith_res : logic_res;
        assign sel_flags = op.mode ? arith_flags : logic_flags;

        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        res   <= '0;
                        cout  <= 1'b0;
                        oflow <= 1'b0;
                        g     <= 1'b0;
                        l     <= 1'b0;
                        e     <= 1'b0;
                        err   <= 1'b0;
                end else if (ce) begin
                        res   <= sel_res;
                        cout  <= sel_flags.cout;
                        oflow <= sel_flags.oflow;
                        g     <= sel_flags.g;
                        l     <= sel_flags.l;
                        e     <= sel_flags.e;
                        err   <= sel_flags.err;
                end
        end

endmodule

// File: hw/alu_pkg.sv
package alu_pkg;

        localparam int CMD_W     = 4;
        localparam int DEFAULT_W = 8;

        // arithmetic commands, mode 1
        localparam logic [CMD_W-1:0] CMD_ADD     = 4'd0;
        localparam logic [CMD_W-1:0] CMD_SUB     = 4'd1;
        localparam logic [CMD_W-1:0] CMD_ADD_CIN = 4'd2;
        localparam logic [CMD_W-1:0] CMD_SUB_CIN = 4'd3;
        localparam logic [CMD_W-1:0] CMD_INC_A   = 4'd4;
        localparam logic [CMD_W-1:0] CMD_DEC_A   = 4'd5;
        localparam logic [CMD_W-1:0] CMD_INC_B   = 4'd6;
        localparam logic [CMD_W-1:0] CMD_DEC_B   = 4'd7;
        localparam logic [CMD_W-1:0] CMD_CMP     = 4'd8;

        // logic commands, mode 0
        localparam logic [CMD_W-1:0] CMD_AND     = 4'd0;
        localparam logic [CMD_W-1:0] CMD_NAND    = 4'd1;
        localparam logic [CMD_W-1:0] CMD_OR      = 4'd2;
        localparam logic [CMD_W-1:0] CMD_NOR     = 4'd3;
        localparam logic [CMD_W-1:0] CMD_XOR     = 4'd4;
        localparam logic [CMD_W-1:0] CMD_XNOR    = 4'd5;
        localparam logic [CMD_W-1:0] CMD_NOT_A   = 4'd6;
        localparam logic [CMD_W-1:0] CMD_NOT_B   = 4'd7;
        localparam logic [CMD_W-1:0] CMD_SHR1_A  = 4'd8;
        localparam logic [CMD_W-1:0] CMD_SHL1_A  = 4'd9;
        localparam logic [CMD_W-1:0] CMD_SHR1_B  = 4'd10;
        localparam logic [CMD_W-1:0] CMD_SHL1_B  = 4'd11;
        localparam logic [CMD_W-1:0] CMD_ROL_A_B = 4'd12;
        localparam logic [CMD_W-1:0] CMD_ROR_A_B = 4'd13;

        // operand-valid codes, 00 is never legal
        localparam logic [1:0] VALID_A  = 2'b01;
        localparam logic [1:0] VALID_B  = 2'b10;
        localparam logic [1:0] VALID_AB = 2'b11;

        typedef struct packed {
                logic cout;
                logic oflow;
                logic g;
                logic l;
                logic e;
                logic err;
        } alu_flags_t;

endpackage

// File: hw/alu_top.sv
`timescale 1ns/1ps

module alu_top #(
        parameter int W = alu_pkg::DEFAULT_W
) (
        input  logic                      clk,
        input  logic                      rst,
        input  logic                      ce,
        input  logic                      mode,
        input  logic                      cin,
        input  logic [1:0]                inp_valid,
        input  logic [alu_pkg::CMD_W-1:0] cmd,
        input  logic [W-1:0]              opa,
        input  logic [W-1:0]              opb,
        output logic [W:0]                res,
        output logic                      cout,
        output logic                      oflow,
        output logic                      g,
        output logic                      l,
        output logic                      e,
        output logic                      err
);
        import alu_pkg::*;

        logic [W:0] arith_res;
        logic [W:0] logic_res;
        alu_flags_t arith_flags;
        alu_flags_t logic_flags;

        alu_op_if #(.W(W)) op_bus ();

        alu_input_stage #(.W(W)) u_input (
                .clk       (clk),
                .rst       (rst),
                .ce        (ce),
                .opa       (opa),
                .opb       (opb),
                .cin       (cin),
                .mode      (mode),
                .cmd       (cmd),
                .inp_valid (inp_valid),
                .op        (op_bus.src)
        );

        // both units evaluate every registered operation
        alu_arith_unit #(.W(W)) u_arith (
                .op    (op_bus.unit),
                .res   (arith_res),
                .flags (arith_flags)
        );

        alu_logic_unit #(.W(W)) u_logic (
                .op    (op_bus.unit),
                .res   (logic_res),
                .flags (logic_flags)
        );

        alu_output_stage #(.W(W)) u_output (
                .clk         (clk),
                .rst         (rst),
                .ce          (ce),
                .op          (op_bus.unit),
                .arith_res   (arith_res),
                .logic_res   (logic_res),
                .arith_flags (arith_flags),
                .logic_flags (logic_flags),
                .res         (res),
                .cout        (cout),
                .oflow       (oflow),
                .g           (g),
                .l           (l),
                .e           (e),
                .err         (err)
        );

endmodule

// File: verification/alu_tb.sv
`timescale 1ns/1ps

module alu_tb;
        import alu_pkg::*;

        localparam int W       = DEFAULT_W;
        localparam int SH      = $clog2(W);
        localparam int NUM_VEC = 400;
        localparam int TIMEOUT = 4 * NUM_VEC + 100;

        typedef struct packed {
                logic [W:0] res;
                alu_flags_t flags;
        } exp_t;

        logic             clk;
        logic             rst;
        logic             ce;
        logic             mode;
        logic             cin;
        logic [1:0]       inp_valid;
        logic [CMD_W-1:0] cmd;
        logic [W-1:0]     opa;
        logic [W-1:0]     opb;
        logic [W:0]       res;
        logic             cout;
        logic             oflow;
        logic             g;
        logic             l;
        logic             e;
        logic             err;

        exp_t exp_q[$];
        exp_t cur_exp = '0;
        exp_t obs;
        logic en_seen = 1'b0;
        int   seed    = 32'h33d3_f6c5;
        int   sent    = 0;
        int   checks  = 0;
        int   errors  = 0;
        int   cycles  = 0;

        alu_top dut (
                .clk       (clk),
                .rst       (rst),
                .ce        (ce),
                .mode      (mode),
                .cin       (cin),
                .inp_valid (inp_valid),
                .cmd       (cmd),
                .opa       (opa),
                .opb       (opb),
                .res       (res),
                .cout      (cout),
                .oflow     (oflow),
                .g         (g),
                .l         (l),
                .e         (e),
                .err       (err)
        );

        initial begin
                clk = 1'b0;
                forever #20 clk = ~clk;
        end

        function automatic logic [W-1:0] rand_word();
                logic [31:0] r;
                r = $random(seed);
                return r[W-1:0];
        endfunction

        // expected result and flags of one operation
        function automatic exp_t alu_model(input logic m, input logic [CMD_W-1:0] c,
                                           input logic [1:0] v, input logic [W-1:0] a,
                                           input logic [W-1:0] b, input logic ci);
                exp_t       r;
                logic       ok;
                logic [W:0] wa;
                logic [W:0] wb;
                logic [W:0] one;
                logic [W:0] ciw;
                logic [W-1:0] y;
                int         amt;
                r   = '0;
                ok  = 1'b0;
                y   = '0;
                wa  = {1'b0, a};
                wb  = {1'b0, b};
                one = {{W{1'b0}}, 1'b1};
                ciw = {{W{1'b0}}, ci};
                if (m) begin
                        case (c)
                                CMD_ADD, CMD_SUB, CMD_ADD_CIN, CMD_SUB_CIN, CMD_CMP:
                                        ok = (v == VALID_AB);
                                CMD_INC_A, CMD_DEC_A: ok = (v == VALID_A) || (v == VALID_AB);
                                CMD_INC_B, CMD_DEC_B: ok = (v == VALID_B) || (v == VALID_AB);
                                default: ok = 1'b0;
                        endcase
                end else begin
                        case (c)
                                CMD_NOT_A, CMD_SHR1_A, CMD_SHL1_A:
                                        ok = (v == VALID_A) || (v == VALID_AB);
                                CMD_NOT_B, CMD_SHR1_B, CMD_SHL1_B:
                                        ok = (v == VALID_B) || (v == VALID_AB);
                                CMD_AND, CMD_NAND, CMD_OR, CMD_NOR, CMD_XOR, CMD_XNOR,
                                CMD_ROL_A_B, CMD_ROR_A_B: ok = (v == VALID_AB);
                                default: ok = 1'b0;
                        endcase
                        // rotate amount lives in the low bits of B only
                        if ((c == CMD_ROL_A_B || c == CMD_ROR_A_B) && (b >> SH) != '0)
                                ok = 1'b0;
                end
                if (!ok) begin
                        r.flags.err = 1'b1;
                        return r;
                end
                if (m) begin
                        case (c)
                                CMD_ADD:     r.res = wa + wb;
                                CMD_ADD_CIN: r.res = wa + wb + ciw;
                                CMD_INC_A:   r.res = wa + one;
                                CMD_INC_B:   r.res = wb + one;
                                CMD_SUB: begin
                                        r.res       = wa - wb;
                                        r.flags.oflow = (a < b);
                                end
                                CMD_SUB_CIN: begin
                                        r.res       = wa - wb - ciw;
                                        r.flags.oflow = (wa < wb + ciw);
                                end
                                CMD_DEC_A: begin
                                        r.res       = wa - one;
                                        r.flags.oflow = (a == '0);
                                end
                                CMD_DEC_B: begin
                                        r.res       = wb - one;
                                        r.flags.oflow = (b == '0);
                                end
                                default: begin
                                        r.flags.g = (a > b);
                                        r.flags.l = (a < b);
                                        r.flags.e = (a == b);
                                end
                        endcase
                        // carry is the top bit of every sum
                        if (c == CMD_ADD || c == CMD_ADD_CIN || c == CMD_INC_A || c == CMD_INC_B)
                                r.flags.cout = r.res[W];
                end else begin
                        case (c)
                                CMD_AND:    y = a & b;
                                CMD_NAND:   y = ~(a & b);
                                CMD_OR:     y = a | b;
                                CMD_NOR:    y = ~(a | b);
                                CMD_XOR:    y = a ^ b;
                                CMD_XNOR:   y = ~(a ^ b);
                                CMD_NOT_A:  y = ~a;
                                CMD_NOT_B:  y = ~b;
                                CMD_SHR1_A: y = a >> 1;
                                CMD_SHL1_A: y = a << 1;
                                CMD_SHR1_B: y = b >> 1;
                                CMD_SHL1_B: y = b << 1;
                                CMD_ROL_A_B: begin
                                        amt = int'(b);
                                        for (int i = 0; i < W; i++)
                                                y[(i + amt) % W] = a[i];
                                end
                                default: begin
                                        amt = int'(b);
                                        for (int i = 0; i < W; i++)
                                                y[i] = a[(i + amt) % W];
                                end
                        endcase
                        r.res = {1'b0, y};
                end
                return r;
        endfunction

        task automatic check_value(input string what, input exp_t got, input exp_t want);
                checks++;
                if (got !== want) begin
                        errors++;
                        $display("Mismatch at %0t: %s res=%h flags=%b, expected res=%h flags=%b",
                                 $time, what, got.res, got.flags, want.res, want.flags);
                end
        endtask

        // one operation, sometimes after a few cycles with ce low
        task automatic send_op(input logic m, input logic [CMD_W-1:0] c, input logic [1:0] v,
                               input logic [W-1:0] a, input logic [W-1:0] b, input logic ci);
                int stall;
                stall = 0;
                if (({$random(seed)} % 5) == 0)
                        stall = 1 + {$random(seed)} % 3;
                repeat (stall) begin
                        ce  <= 1'b0;
                        opa <= rand_word();
                        opb <= rand_word();
                        @(posedge clk);
                end
                ce        <= 1'b1;
                mode      <= m;
                cmd       <= c;
                inp_valid <= v;
                opa       <= a;
                opb       <= b;
                cin       <= ci;
                @(posedge clk);
                exp_q.push_back(alu_model(m, c, v, a, b, ci));
                sent++;
        endtask

        // value of ce the DUT saw at this edge
        always @(posedge clk) begin
                en_seen = ce && !rst;
        end

        always @(negedge clk) begin
                if (en_seen) begin
                        if (exp_q.size() == 0) begin
                                errors++;
                                $display("Error at %0t: enabled edge with no expected result queued",
                                         $time);
                        end else begin
                                cur_exp = exp_q.pop_front();
                        end
                end
                obs = {res, cout, oflow, g, l, e, err};
                check_value("outputs", obs, cur_exp);
        end

        always @(posedge clk) begin
                cycles++;
                if (cycles > TIMEOUT) begin
                        $display("Run timed out after %0d cycles", cycles);
                        $display("SIMULATION FAILED");
                        $finish;
                end
        end

        initial begin
                logic [31:0]      r;
                logic             m;
                logic [CMD_W-1:0] c;
                logic [1:0]       v;
                logic [W-1:0]     b;
                rst       = 1'b1;
                ce        = 1'b0;
                mode      = 1'b0;
                cin       = 1'b0;
                inp_valid = 2'b00;
                cmd       = '0;
                opa       = '0;
                opb       = '0;
                // the cleared input register reaches the outputs at the first enabled edge
                exp_q.push_back(alu_model(1'b0, '0, 2'b00, '0, '0, 1'b0));
                repeat (3) @(posedge clk);
                rst <= 1'b0;

                // operand extremes and both cin values
                for (int i = 0; i < 9; i++)
                        for (int j = 0; j < 4; j++)
                                for (int k = 0; k < 2; k++)
                                        send_op(1'b1, i[CMD_W-1:0], VALID_AB, {W{j[0]}},
                                                {W{j[1]}}, k[0]);
                for (int j = 0; j < 2; j++) begin
                        send_op(1'b1, CMD_INC_A, VALID_A, {W{j[0]}}, rand_word(), 1'b0);
                        send_op(1'b1, CMD_DEC_A, VALID_A, {W{j[0]}}, rand_word(), 1'b0);
                        send_op(1'b1, CMD_INC_B, VALID_B, rand_word(), {W{j[0]}}, 1'b0);
                        send_op(1'b1, CMD_DEC_B, VALID_B, rand_word(), {W{j[0]}}, 1'b0);
                end

                // every legal rotate amount, then out-of-range ones
                for (int i = 0; i < W; i++) begin
                        send_op(1'b0, CMD_ROL_A_B, VALID_AB, rand_word(), i[W-1:0], 1'b0);
                        send_op(1'b0, CMD_ROR_A_B, VALID_AB, rand_word(), i[W-1:0], 1'b0);
                end
                for (int i = 0; i < 6; i++) begin
                        b     = rand_word();
                        b[SH] = 1'b1;
                        send_op(1'b0, i[0] ? CMD_ROL_A_B : CMD_ROR_A_B, VALID_AB,
                                rand_word(), b, 1'b0);
                end

                // invalid operand codes and commands
                for (int i = 0; i < 16; i++)
                        send_op(i[0], i[CMD_W-1:0], 2'b00, rand_word(), rand_word(), 1'b0);
                send_op(1'b1, CMD_ADD, VALID_A, rand_word(), rand_word(), 1'b0);
                send_op(1'b1, CMD_SUB, VALID_B, rand_word(), rand_word(), 1'b0);
                send_op(1'b1, CMD_CMP, VALID_A, rand_word(), rand_word(), 1'b0);
                send_op(1'b0, CMD_AND, VALID_A, rand_word(), rand_word(), 1'b0);
                send_op(1'b0, CMD_ROL_A_B, VALID_B, rand_word(), W'(3), 1'b0);
                send_op(1'b0, 4'd14, VALID_AB, rand_word(), rand_word(), 1'b0);
                send_op(1'b0, 4'd15, VALID_AB, rand_word(), rand_word(), 1'b0);

                // random mix of both modes
                while (sent < NUM_VEC) begin
                        r = $random(seed);
                        m = r[0];
                        c = r[7:4];
                        if (m && c > CMD_CMP)
                                c = c - CMD_CMP;
                        v = (r[9:8] == 2'b00) ? r[11:10] : VALID_AB;
                        send_op(m, c, v, rand_word(), rand_word(), r[12]);
                end

                // one more enabled edge pushes the last result out
                send_op(1'b0, CMD_AND, VALID_AB, '0, '0, 1'b0);
                ce <= 1'b0;
                while (exp_q.size() > 1)
                        @(posedge clk);
                repeat (3) @(posedge clk);

                $display("Checks: %0d, errors: %0d", checks, errors);
                if (errors == 0)
                        $display("SIMULATION PASSED");
                else
                        $display("SIMULATION FAILED");
                $finish;
        end

endmodule
